// File: vlog.f
hw/usiPkg.sv
hw/microControllerCsr.sv
hw/usiBusIssue.sv
hw/usiSlotBank.sv
hw/microControllerTop.sv
test/tbMicroController.sv

// File: run.sh
#!/usr/bin/env bash
# Build the peripheral fabric testbench with Verilator and run it.
# The exit status is non-zero when the build fails or the run does not pass.
set -u

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG_FILE=sim.log

verilator --binary --timing --assert -Wno-fatal \
	-f vlog.f --top-module tbMicroController --Mdir "$BUILD_DIR"
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

"./$BUILD_DIR/VtbMicroController" > "$LOG_FILE" 2>&1
simStatus=$?
cat "$LOG_FILE"
if [ $simStatus -ne 0 ]; then
	echo "Simulation exited with status $simStatus"
	exit 1
fi

if grep -q "^SIMULATION PASSED$" "$LOG_FILE"; then
	exit 0
fi
echo "Pass line not found in $LOG_FILE"
exit 1

// File: test/tbMicroController.sv
/*
 Testbench of the peripheral fabric top level.
 Random CSR and bus writes from a fixed seed, checked against a register and slot model.
*/
module tbMicroController;
	import usiPkg::*;

	localparam int       pollLimit = 200;	// Cycles per poll before giving up
	localparam slotMaskT allRdy    = '1;

	logic     iSysClk;
	logic     rstN;
	adrsT     adrs;
	dataT     wd;
	logic     cke;
	dataT     rd;

	// Model of the manual registers and the slot words
	dataT     expMWd;
	dataT     expMAdrs;
	dataT     modelStore [slotNum][4];
	wordSelT  modelSel [slotNum];		// Word select of the last write per slot

	microControllerTop u_dut (
		.iSysClk (iSysClk),
		.rstN    (rstN),
		.adrs    (adrs),
		.wd      (wd),
		.cke     (cke),
		.rd      (rd)
	);

	initial
	begin
		iSysClk = 1'b0;
		forever #5 iSysClk = ~iSysClk;
	end

	// ----------------------------------------
	// Compare and failure tasks
	// ----------------------------------------
	task automatic checkData(input string name, input dataT exp, input dataT act);
		if (act !== exp)
		begin
			$display("FAILED %s: expected %h, actual %h", name, exp, act);
			$display("SIMULATION FAILED");
			$fatal(1, "Data mismatch");
		end
	endtask

	task automatic checkMask(input string name, input slotMaskT exp, input slotMaskT act);
		if (act !== exp)
		begin
			$display("FAILED %s: expected %h, actual %h", name, exp, act);
			$display("SIMULATION FAILED");
			$fatal(1, "Mask mismatch");
		end
	endtask

	task automatic timeoutFail(input string what);
		$display("Timeout after %0d cycles while waiting for %s", pollLimit, what);
		$display("SIMULATION FAILED");
		$fatal(1, "Poll timeout");
	endtask

	// ----------------------------------------
	// Processor port access, entered right after a falling edge
	// ----------------------------------------
	task automatic writeReg(input adrsT a, input dataT d);
		adrs = a;
		wd   = d;
		cke  = 1'b1;
		@(negedge iSysClk);
		cke  = 1'b0;
	endtask

	task automatic readReg(input adrsT a, output dataT v);
		adrs = a;
		cke  = 1'b0;
		@(negedge iSysClk);
		v = rd;		// Registered one edge after the address
	endtask

	// ----------------------------------------
	// Model and completion
	// ----------------------------------------
	task automatic applyModel(input dataT d, input dataT a, input slotMaskT m);
		for (int k = 0; k < slotNum; k++)
		begin
			if (m[k])
			begin
				modelStore[k][a[1:0]] = d;
				modelSel[k]           = a[1:0];
			end
		end
	endtask

	task automatic waitDone(input string name);
		dataT v;
		int   n;
		n = 0;
		readReg(adrsMCke, v);
		while ((v != '0) && (n < pollLimit))
		begin
			readReg(adrsMCke, v);
			n++;
		end
		if (v != '0)
			timeoutFail({name, " mask clear"});
		n = 0;
		readReg(adrsSRdy, v);
		while ((slotMaskT'(v) != allRdy) && (n < pollLimit))
		begin
			readReg(adrsSRdy, v);
			n++;
		end
		if (slotMaskT'(v) != allRdy)
			timeoutFail({name, " slots ready"});
		readReg(adrsSCke, v);
		checkMask({name, " strobes idle"}, '0, slotMaskT'(v));	// No return left
	endtask

	task automatic checkSlots(input string name);
		dataT v;
		for (int k = 0; k < slotNum; k++)
		begin
			readReg(adrsT'(adrsSBase + 4 * k), v);
			checkData($sformatf("%s slot %0d", name, k), modelStore[k][modelSel[k]], v);
		end
	endtask

	task automatic checkManual(input string name);
		dataT v;
		readReg(adrsMWd, v);
		checkData({name, " mWd"}, expMWd, v);
		readReg(adrsMAdrs, v);
		checkData({name, " mAdrs"}, expMAdrs, v);
	endtask

	task automatic busWrite(input string name, input dataT d, input dataT a, input slotMaskT m);
		writeReg(adrsMWd, d);
		writeReg(adrsMAdrs, a);
		writeReg(adrsMCke, dataT'(m));	// Starts the bus write
		expMWd   = d;
		expMAdrs = a;
		applyModel(d, a, m);
		waitDone(name);
		checkSlots(name);
		checkManual(name);
	endtask

	function automatic slotMaskT randMask();
		slotMaskT m;
		m = slotMaskT'($urandom);
		if (m == '0)
			m = slotMaskT'(1);	// Zero would start nothing
		return m;
	endfunction

	// ----------------------------------------
	// Test sequence
	// ----------------------------------------
	initial
	begin
		dataT     v;
		dataT     prev;
		dataT     d1;
		dataT     a1;
		dataT     d2;
		dataT     a2;
		slotMaskT m1;
		slotMaskT m2;
		void'($urandom(2575));
		rstN = 1'b0;
		adrs = '0;
		wd   = '0;
		cke  = 1'b0;
		expMWd   = '0;
		expMAdrs = '0;
		for (int k = 0; k < slotNum; k++)
		begin
			for (int w = 0; w < 4; w++)
				modelStore[k][w] = '0;
			modelSel[k] = '0;
		end
		repeat (8) @(posedge iSysClk);
		@(negedge iSysClk);
		rstN = 1'b1;
		@(negedge iSysClk);

		// Reset values
		checkManual("reset");
		readReg(adrsMCke, v);
		checkData("reset mCke", '0, v);
		checkSlots("reset");
		readReg(adrsSCke, v);
		checkData("reset sCke", '0, v);
		readReg(adrsSRdy, v);
		checkData("reset sRdy", dataT'(allRdy), v);

		// Manual register read-back
		for (int i = 0; i < 8; i++)
		begin
			expMWd   = dataT'($urandom);
			expMAdrs = dataT'($urandom);
			writeReg(adrsMWd, expMWd);
			writeReg(adrsMAdrs, expMAdrs);
			checkManual($sformatf("manual %0d", i));
		end

		// Single slot writes
		for (int i = 0; i < 12; i++)
			busWrite($sformatf("single %0d", i), dataT'($urandom), dataT'($urandom),
				slotMaskT'(1) << ($urandom % slotNum));

		// Multi slot masks
		for (int i = 0; i < 8; i++)
			busWrite($sformatf("multi %0d", i), dataT'($urandom), dataT'($urandom), randMask());

		// Holes keep the last read word
		readReg(adrsMWd, prev);
		checkData("hole prev", expMWd, prev);
		readReg(8'h0c, v);
		checkData("hole 0c", prev, v);
		readReg(8'h10, v);
		checkData("hole 10", prev, v);
		for (int i = 0; i < 6; i++)
		begin
			readReg(adrsT'(8'h44 + ($urandom % 8'hbc)), v);	// Above the map
			checkData($sformatf("hole high %0d", i), prev, v);
			readReg(adrsT'(8'h15 + 4 * ($urandom % slotNum)), v);	// Misaligned slot word
			checkData($sformatf("hole misaligned %0d", i), prev, v);
		end

		// Second mask while the first write is in flight
		for (int i = 0; i < 6; i++)
		begin
			d1 = dataT'($urandom);
			a1 = dataT'($urandom);
			d2 = dataT'($urandom);
			a2 = dataT'($urandom);
			m1 = randMask();
			m2 = m1 | slotMaskT'($urandom);	// Overlap forces back-pressure
			writeReg(adrsMWd, d1);
			writeReg(adrsMAdrs, a1);
			writeReg(adrsMCke, dataT'(m1));
			applyModel(d1, a1, m1);
			writeReg(adrsMWd, d2);		// Payload of the first write is already frozen
			writeReg(adrsMAdrs, a2);
			expMWd   = d2;
			expMAdrs = a2;
			v = dataT'(m1);
			for (int n = 0; (n < pollLimit) && (v != '0); n++)
				readReg(adrsMCke, v);
			if (v != '0)
				timeoutFail("first mask clear");
			writeReg(adrsMCke, dataT'(m2));
			applyModel(d2, a2, m2);
			readReg(adrsMCke, v);
			checkMask($sformatf("overlap %0d held", i), m2, slotMaskT'(v));
			waitDone($sformatf("overlap %0d", i));
			checkSlots($sformatf("overlap %0d", i));
			checkManual($sformatf("overlap %0d", i));
		end

		$display("SIMULATION PASSED");
		$finish;
	end

endmodule

// File: hw/microControllerTop.sv
/*
 Top of the peripheral fabric: CSR, issue stage and slot bank in a ring.
 The processor sees only the CSR address, data, write strobe and read word.
*/
module microControllerTop (
	input  logic         iSysClk,
	input  logic         rstN,
	input  usiPkg::adrsT adrs,
	input  usiPkg::dataT wd,
	input  logic         cke,
	output usiPkg::dataT rd
);
	import usiPkg::*;

	// CSR to issue
	dataT     mWd;
	dataT     mAdrs;
	slotMaskT mCke;
	logic     issued;

	// Issue to bank
	dataT     usiWd;
	wordSelT  usiWordSel;
	slotMaskT usiCke;

	// Bank back to CSR and issue
	slotMaskT slotRdy;
	dataT     retRd;
	slotMaskT retCke;

	// ----------------------------------------
	// Stages
	// ----------------------------------------
	microControllerCsr uCsr (
		.iSysClk (iSysClk),
		.rstN    (rstN),
		.adrs    (adrs),
		.wd      (wd),
		.cke     (cke),
		.rd      (rd),
		.mWd     (mWd),
		.mAdrs   (mAdrs),
		.mCke    (mCke),
		.issued  (issued),
		.retRd   (retRd),
		.retCke  (retCke),
		.slotRdy (slotRdy)
	);

	usiBusIssue uIssue (
		.iSysClk    (iSysClk),
		.rstN       (rstN),
		.mWd        (mWd),
		.mAdrs      (mAdrs),
		.mCke       (mCke),
		.slotRdy    (slotRdy),
		.usiWd      (usiWd),
		.usiWordSel (usiWordSel),
		.usiCke     (usiCke),
		.issued     (issued)
	);

	usiSlotBank uBank (
		.iSysClk    (iSysClk),
		.rstN       (rstN),
		.usiWd      (usiWd),
		.usiWordSel (usiWordSel),
		.usiCke     (usiCke),
		.slotRdy    (slotRdy),
		.retRd      (retRd),
		.retCke     (retCke)
	);

endmodule

// File: hw/usiSlotBank.sv
/*
 Stand-in for the ten bus peripherals.
 Each slot stores the word written to it, stays busy for a fixed time, then
 returns the word. Pending answers leave one per clock, lowest slot first.
*/
module usiSlotBank (
	input  logic             iSysClk,
	input  logic             rstN,
	input  usiPkg::dataT     usiWd,
	input  usiPkg::wordSelT  usiWordSel,
	input  usiPkg::slotMaskT usiCke,
	output usiPkg::slotMaskT slotRdy,
	output usiPkg::dataT     retRd,
	output usiPkg::slotMaskT retCke
);
	import usiPkg::*;

	typedef logic [$clog2(busyCycles + 1) - 1:0] busyCntT;

	dataT     store [slotNum][4];	// Four words per slot
	wordSelT  lastSel [slotNum];	// Word of the last write, returned later
	busyCntT  busyCnt [slotNum];	// Clocks left in the busy window
	slotMaskT pending;				// Answer waiting for the return bus
	slotIdxT  pickIdx;				// Lowest pending slot
	logic     anyPending;

	// ----------------------------------------
	// Word store
	// ----------------------------------------
	always_ff @(posedge iSysClk)
	begin
		for (int k = 0; k < slotNum; k++)
		begin
			if (usiCke[k])
			begin
				store[k][usiWordSel] <= usiWd;
				lastSel[k]           <= usiWordSel;
			end
		end
	end

	// ----------------------------------------
	// Busy timing and pending flags
	// ----------------------------------------
	always_ff @(posedge iSysClk or negedge rstN)
	begin
		if (!rstN)
		begin
			for (int k = 0; k < slotNum; k++)
				busyCnt[k] <= '0;
			pending <= '0;
		end
		else
		begin
			for (int k = 0; k < slotNum; k++)
			begin
				if (usiCke[k])
					busyCnt[k] <= busyCntT'(busyCycles);	// Open busy window
				else if (busyCnt[k] != '0)
					busyCnt[k] <= busyCnt[k] - 1'b1;
				// Last busy clock hands over to pending
				if (busyCnt[k] == busyCntT'(1))
					pending[k] <= 1'b1;
				else if (retCke[k])
					pending[k] <= 1'b0;		// Answer taken, slot ready again
			end
		end
	end

	always_comb
	begin
		for (int k = 0; k < slotNum; k++)
			slotRdy[k] = (busyCnt[k] == '0) && !pending[k];
	end

	// ----------------------------------------
	// Return pick
	// ----------------------------------------
	always_comb
	begin
		pickIdx = '0;
		// Walk down so the lowest pending index wins
		for (int k = slotNum - 1; k >= 0; k--)
		begin
			if (pending[k])
				pickIdx = slotIdxT'(k);
		end
	end

	assign anyPending = |pending;
	assign retRd  = anyPending ? store[pickIdx][lastSel[pickIdx]] : '0;
	assign retCke = anyPending ? (slotMaskT'(1) << pickIdx) : '0;

	// Write strobes arrive as single-clock pulses
	strobePulse: assert property (@(posedge iSysClk) disable iff (!rstN)
		(usiCke != '0) |=> (usiCke == '0));

endmodule

// File: hw/usiBusIssue.sv
/*
 Issue stage of the peripheral bus.
 Latches the manual registers and sends one write strobe once all targets are ready.
*/
module usiBusIssue (
	input  logic             iSysClk,
	input  logic             rstN,
	input  usiPkg::dataT     mWd,
	input  usiPkg::dataT     mAdrs,
	input  usiPkg::slotMaskT mCke,
	input  usiPkg::slotMaskT slotRdy,
	output usiPkg::dataT     usiWd,
	output usiPkg::wordSelT  usiWordSel,
	output usiPkg::slotMaskT usiCke,
	output logic             issued
);
	import usiPkg::*;

	issueStateT state;
	slotMaskT   maskQ;			// Targets of the write in flight
	logic       start;			// Mask seen while idle
	logic       targetsRdy;		// Every target can take a word

	assign start      = (state == issueIdle) && (mCke != '0);
	assign targetsRdy = (maskQ & ~slotRdy) == '0;

	// ----------------------------------------
	// FSM
	// ----------------------------------------
	always_ff @(posedge iSysClk or negedge rstN)
	begin
		if (!rstN)
		begin
			state <= issueIdle;
			maskQ <= '0;
		end
		else
		begin
			case (state)
				issueIdle:
				begin
					if (start)
					begin
						state <= issueWait;
						maskQ <= mCke;		// Later mask writes wait in the CSR
					end
				end
				issueWait:
				begin
					if (targetsRdy)
						state <= issueDrive;	// Back-pressure ends here
				end
				issueDrive:
					state <= issueIdle;		// Single strobe cycle
				default:
					state <= issueIdle;
			endcase
		end
	end

	// Payload frozen with the mask
	always_ff @(posedge iSysClk)
	begin
		if (start)
		begin
			usiWd      <= mWd;
			usiWordSel <= mAdrs[1:0];
		end
	end

	assign usiCke = (state == issueDrive) ? maskQ : '0;
	assign issued = state == issueDrive;

	// Never strobe a slot that is still busy
	strobeOnReady: assert property (@(posedge iSysClk) disable iff (!rstN)
		(usiCke & ~slotRdy) == '0);

endmodule

// File: hw/microControllerCsr.sv
/*
 Control and status registers of the peripheral fabric.
 Processor writes land in the manual registers, slot answers in the auto registers.
 Reads go through a registered mux, valid one clock after the address.
*/
module microControllerCsr (
	input  logic             iSysClk,
	input  logic             rstN,
	// Processor side
	input  usiPkg::adrsT     adrs,
	input  usiPkg::dataT     wd,
	input  logic             cke,
	output usiPkg::dataT     rd,
	// To the issue stage
	output usiPkg::dataT     mWd,
	output usiPkg::dataT     mAdrs,
	output usiPkg::slotMaskT mCke,
	input  logic             issued,
	// From the slot bank
	input  usiPkg::dataT     retRd,
	input  usiPkg::slotMaskT retCke,
	input  usiPkg::slotMaskT slotRdy
);
	import usiPkg::*;

	dataT     sRd [slotNum];	// Captured answer per slot
	slotMaskT sCke;				// Return strobes, one clock late
	slotMaskT sRdy;				// Ready levels, one clock late

	logic     wrMWd;
	logic     wrMAdrs;
	logic     wrMCke;

	adrsT     slotOfs;			// Address relative to slot 0
	slotIdxT  slotSel;
	logic     slotHit;			// Address lands on a slot read word

	// ----------------------------------------
	// Manual registers
	// ----------------------------------------
	assign wrMWd   = cke && (adrs == adrsMWd);
	assign wrMAdrs = cke && (adrs == adrsMAdrs);
	assign wrMCke  = cke && (adrs == adrsMCke);

	always_ff @(posedge iSysClk or negedge rstN)
	begin
		if (!rstN)
		begin
			mWd   <= '0;
			mAdrs <= '0;
			mCke  <= '0;
		end
		else
		begin
			if (wrMWd)
				mWd <= wd;
			if (wrMAdrs)
				mAdrs <= wd;
			// Processor write beats the auto clear
			if (wrMCke)
				mCke <= slotMaskT'(wd);
			else if (issued)
				mCke <= '0;		// Write went out, mask done
		end
	end

	// ----------------------------------------
	// Auto registers
	// ----------------------------------------
	always_ff @(posedge iSysClk or negedge rstN)
	begin
		if (!rstN)
		begin
			for (int k = 0; k < slotNum; k++)
				sRd[k] <= '0;
			sCke <= '0;
			sRdy <= '0;		// Follows slotRdy from the first clock on
		end
		else
		begin
			for (int k = 0; k < slotNum; k++)
			begin
				if (retCke[k])
					sRd[k] <= retRd;	// Only the strobed slot takes the word
			end
			sCke <= retCke;
			sRdy <= slotRdy;
		end
	end

	// ----------------------------------------
	// Read mux
	// ----------------------------------------
	always_comb
	begin
		slotOfs = adrs - adrsSBase;
		slotSel = slotOfs[5:2];
		// Word aligned and inside the ten slot words
		slotHit = (adrs >= adrsSBase) && (slotOfs[1:0] == 2'b00) &&
			(slotOfs[7:2] < slotNum);
	end

	always_ff @(posedge iSysClk or negedge rstN)
	begin
		if (!rstN)
			rd <= '0;
		else if (slotHit)
			rd <= sRd[slotSel];
		else
		begin
			case (adrs)
				adrsMWd:   rd <= mWd;
				adrsMAdrs: rd <= mAdrs;
				adrsMCke:  rd <= dataT'(mCke);
				adrsSCke:  rd <= dataT'(sCke);
				adrsSRdy:  rd <= dataT'(sRdy);
				default:   rd <= rd;		// 'h0c, 'h10 and holes keep the last word
			endcase
		end
	end

	// One answer per clock, and only from a slot still marked busy
	retFromBusySlot: assert property (@(posedge iSysClk) disable iff (!rstN)
		$onehot0(retCke) && ((retCke & slotRdy) == '0));

endmodule

// File: hw/usiPkg.sv
/*
 Shared widths, CSR register map and slot count of the peripheral bus fabric.
 Import into every block that touches the CSR map or the slot bus.
*/
package usiPkg;

	// ----------------------------------------
	// Sizes
	// ----------------------------------------
	localparam int slotNum    = 10;	// Peripheral slots on the bus, fixes the map
	localparam int busyCycles = 3;	// Clocks a slot stays busy per write

	typedef logic [31:0]        dataT;		// Bus word and CSR word
	typedef logic [7:0]         adrsT;		// CSR byte address
	typedef logic [slotNum-1:0] slotMaskT;	// One bit per slot
	typedef logic [3:0]         slotIdxT;	// Slot number
	typedef logic [1:0]         wordSelT;	// Word inside a slot, bus address [1:0]

	// ----------------------------------------
	// CSR map
	// ----------------------------------------
	// Manual registers, written by the processor
	localparam adrsT adrsMWd   = 8'h00;	// Bus write data
	localparam adrsT adrsMAdrs = 8'h04;	// Bus write address
	localparam adrsT adrsMCke  = 8'h08;	// Target mask, clears after issue

	// Auto registers, written by the fabric
	localparam adrsT adrsSBase = 8'h14;	// Slot 0 read word, stride 4 up to 'h38
	localparam adrsT adrsSCke  = 8'h3c;	// Last return strobes
	localparam adrsT adrsSRdy  = 8'h40;	// Slot ready levels

	// ----------------------------------------
	// Issue FSM
	// ----------------------------------------
	typedef enum logic [1:0]
	{
		issueIdle,	// No mask pending
		issueWait,	// Mask latched, targets still busy
		issueDrive	// Strobe on the bus this cycle
	} issueStateT;

endpackage
